/* logic/opc_defines.svh */
`ifndef OPC_DEFINES_SVH
`define OPC_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define OPC_WORD_W      16                     // Data and address.
`define OPC_REG_IDX_W   4                      // 16 registers.
`define OPC_MEM_AW      12                     // RAM index bits.
`define OPC_MEM_DEPTH   (1 << `OPC_MEM_AW)     // 4096 words.

////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////

`define OPC_IO_PAGE_W   8                      // Top address byte.
`define OPC_IO_PAGE     8'hff
`define OPC_IO_OUT_ADDR 16'hff00
`define OPC_IO_IN_ADDR  16'hff01

`endif

/* logic/opc_pkg.sv */
`include "opc_defines.svh"

package opc_pkg;

   typedef logic [`OPC_WORD_W-1:0]    word_t;
   typedef logic [`OPC_MEM_AW-1:0]    mem_addr_t;
   typedef logic [`OPC_REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [1:0] {
      OP_LD   = 2'd0,
      OP_ADD  = 2'd1,
      OP_NAND = 2'd2,
      OP_STO  = 2'd3
   } opcode_t;

   typedef enum logic [2:0] {
      fetch0,
      fetch1,
      ea_ed,
      rdmem,
      exec,
      wrmem
   } cpu_state_e;

   // First instruction word, msb first.
   typedef struct packed {
      logic     pred_c;
      logic     pred_nz;
      logic     spare;
      logic     indirect;
      opcode_t  op;
      logic [1:0] rsvd;                        // Bits 9:8.
      reg_idx_t src;
      reg_idx_t dst;
   } instr_t;

   typedef struct packed {
      word_t address;
      word_t wdata;
      logic  write;
   } cpu_bus_t;

   typedef struct packed {
      logic      en;
      mem_addr_t address;
      word_t     data;
   } load_t;

endpackage

/* logic/opc_cpu.sv */
`timescale 1ns/1ps

module opc_cpu
   import opc_pkg::*;
(
   input  logic     clk,
   input  logic     reset_b,
   input  word_t    rdata,
   output cpu_bus_t bus
);

   ////////////////////////////////////////////////////////////
   // State and datapath registers
   ////////////////////////////////////////////////////////////

   cpu_state_e state;
   instr_t     ir_q;
   word_t      or_q;                           // Operand, then effective value.
   word_t      pc_q;
   word_t      grf_q [0:(1 << $bits(reg_idx_t))-1];
   logic       c_q;
   logic       z_q;

   reg_idx_t   grf_radr;
   word_t      grf_dout;
   word_t      result;
   logic       carry;
   logic       pred_ok;
   logic       dst_is_pc;

   assign dst_is_pc = (ir_q.dst == '1);
   assign pred_ok   = (ir_q.pred_c | c_q) & (ir_q.pred_nz | ~z_q);

   // Source register for the address, destination for ALU and store.
   assign grf_radr = (state == exec || state == wrmem) ? ir_q.dst : ir_q.src;

   always_comb
   begin
      if (grf_radr == '1)
         grf_dout = pc_q;                      // r15 is the PC.
      else if (grf_radr == '0)
         grf_dout = '0;                        // r0 reads as zero.
      else
         grf_dout = grf_q[grf_radr];
   end

   ////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      carry  = c_q;
      result = or_q;
      case (ir_q.op)
         OP_ADD:
         begin
            {carry, result} = {1'b0, grf_dout} + {1'b0, or_q};
         end
         OP_NAND:
         begin
            result = ~(grf_dout & or_q);
         end
         default:
         begin
            result = or_q;                     // Load passes the operand.
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= fetch0;
      else
      begin
         case (state)
            fetch0:
               state <= fetch1;
            fetch1:
               state <= pred_ok ? ea_ed : fetch0;  // Skip on failed predicate.
            ea_ed:
            begin
               if (ir_q.indirect)
                  state <= rdmem;
               else if (ir_q.op == OP_STO)
                  state <= wrmem;
               else
                  state <= exec;
            end
            rdmem:
               state <= (ir_q.op == OP_STO) ? wrmem : exec;
            default:
               state <= fetch0;
         endcase
      end
   end

   // Instruction and operand words.
   always_ff @(posedge clk)
   begin
      case (state)
         fetch0:
            ir_q <= instr_t'(rdata);
         fetch1, rdmem:
            or_q <= rdata;
         ea_ed:
            or_q <= grf_dout + or_q;           // Effective value.
         default:
            or_q <= or_q;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc_q <= '0;
      else if (state == fetch0 || state == fetch1)
         pc_q <= pc_q + 1'b1;
      else if (state == exec && dst_is_pc)
         pc_q <= result;                       // Jump.
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         c_q <= 1'b0;
         z_q <= 1'b0;
      end
      else if (state == exec)
      begin
         c_q <= carry;
         z_q <= (result == '0);
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == exec && !dst_is_pc)
         grf_q[ir_q.dst] <= result;
   end

   ////////////////////////////////////////////////////////////
   // Bus request
   ////////////////////////////////////////////////////////////

   assign bus.address = (state == rdmem || state == wrmem) ? or_q : pc_q;
   assign bus.wdata   = grf_dout;
   assign bus.write   = (state == wrmem);

   // A write belongs to a store and lasts one cycle before the next fetch.
   a_write_store: assert property (@(posedge clk) disable iff (!reset_b)
      bus.write |-> (ir_q.op == OP_STO) ##1 (!bus.write && state == fetch0));

   a_state_legal: assert property (@(posedge clk) disable iff (!reset_b)
      !$isunknown(state) && (state inside {fetch0, fetch1, ea_ed, rdmem, exec, wrmem}));

endmodule

/* logic/opc_memory.sv */
`timescale 1ns/1ps
`include "opc_defines.svh"

module opc_memory
   import opc_pkg::*;
(
   input  logic     clk,
   input  cpu_bus_t bus,
   input  load_t    load,
   output word_t    rdata
);

   word_t     mem [0:`OPC_MEM_DEPTH-1];
   mem_addr_t cpu_idx;
   logic      io_page;
   logic      cpu_we;

   assign cpu_idx = bus.address[`OPC_MEM_AW-1:0];
   assign io_page = (bus.address[`OPC_WORD_W-1 -: `OPC_IO_PAGE_W] == `OPC_IO_PAGE);
   assign cpu_we  = bus.write && !io_page;

   ////////////////////////////////////////////////////////////
   // Write ports
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (load.en)
         mem[load.address] <= load.data;       // Program load in reset.
      else if (cpu_we)
         mem[cpu_idx] <= bus.wdata;
   end

   // Asynchronous read.
   assign rdata = mem[cpu_idx];

   // Loading runs only while the CPU is held in reset.
   a_no_write_clash: assert property (@(posedge clk)
      !(cpu_we && load.en));

endmodule

/* logic/opc_io_port.sv */
`timescale 1ns/1ps
`include "opc_defines.svh"

module opc_io_port
   import opc_pkg::*;
(
   input  logic     clk,
   input  logic     reset_b,
   input  cpu_bus_t bus,
   input  word_t    in_port,
   output word_t    rdata,
   output word_t    out_port,
   output logic     out_strobe
);

   logic out_we;

   assign out_we = bus.write && (bus.address == `OPC_IO_OUT_ADDR);

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         out_port   <= '0;
         out_strobe <= 1'b0;
      end
      else
      begin
         out_strobe <= out_we;                 // High for one cycle.
         if (out_we)
            out_port <= bus.wdata;
      end
   end

   // Other page addresses read back the output register.
   assign rdata = (bus.address == `OPC_IO_IN_ADDR) ? in_port : out_port;

endmodule

/* logic/opc_bus_return.sv */
`timescale 1ns/1ps
`include "opc_defines.svh"

module opc_bus_return
   import opc_pkg::*;
(
   input  word_t address,
   input  word_t mem_rdata,
   input  word_t io_rdata,
   output word_t rdata
);

   logic io_sel;
   logic ram_in_range;

   assign io_sel       = (address[`OPC_WORD_W-1 -: `OPC_IO_PAGE_W] == `OPC_IO_PAGE);
   assign ram_in_range = (address[`OPC_WORD_W-1:`OPC_MEM_AW] == '0);

   // Same cycle return to the CPU.
   assign rdata = io_sel ? io_rdata : mem_rdata;

   // Addresses above the RAM and below the I/O page would alias.
   always_comb
   begin
      a_ram_range: assert #0 ($isunknown(address) || io_sel || ram_in_range);
   end

endmodule

/* logic/opc_system.sv */
`timescale 1ns/1ps

module opc_system
   import opc_pkg::*;
(
   input  logic  clk,
   input  logic  reset_b,
   input  load_t load,
   input  word_t in_port,
   output word_t out_port,
   output logic  out_strobe
);

   cpu_bus_t bus;
   word_t    cpu_rdata;
   word_t    mem_rdata;
   word_t    io_rdata;

   ////////////////////////////////////////////////////////////
   // CPU
   ////////////////////////////////////////////////////////////

   opc_cpu u_cpu (
      .clk     (clk),
      .reset_b (reset_b),
      .rdata   (cpu_rdata),
      .bus     (bus)
   );

   ////////////////////////////////////////////////////////////
   // Memory and I/O
   ////////////////////////////////////////////////////////////

   opc_memory u_memory (
      .clk   (clk),
      .bus   (bus),
      .load  (load),
      .rdata (mem_rdata)
   );

   opc_io_port u_io_port (
      .clk        (clk),
      .reset_b    (reset_b),
      .bus        (bus),
      .in_port    (in_port),
      .rdata      (io_rdata),
      .out_port   (out_port),
      .out_strobe (out_strobe)
   );

   opc_bus_return u_bus_return (
      .address   (bus.address),
      .mem_rdata (mem_rdata),
      .io_rdata  (io_rdata),
      .rdata     (cpu_rdata)
   );

endmodule

/* verif/opc_system_tb.sv */
`timescale 1ns/1ps
`include "opc_defines.svh"

module opc_system_tb
   import opc_pkg::*;
();

   localparam int clk_half       = 10;
   localparam int drive_delay    = 1;
   localparam int reset_cycles   = 3;
   localparam int tail_cycles    = 16;     // Skipped store plus halt jumps.
   localparam int timeout_cycles = 3000;   // Six programs under 150 cycles each.

   // Predicate bits {pred_c, pred_nz}.
   localparam logic [1:0] run_always   = 2'b11;
   localparam logic [1:0] run_if_carry = 2'b01;
   localparam logic [1:0] run_if_nz    = 2'b10;

   logic  clk;
   logic  reset_b;
   load_t load;
   word_t in_port;
   word_t out_port;
   logic  out_strobe;

   word_t     prog_q [$];
   mem_addr_t extra_addr_q [$];
   word_t     extra_data_q [$];
   word_t     exp_q [$];
   word_t     out_q [$];

   string  current_test;
   int     test_errors;
   int     error_count;
   int     tests_run;
   int     tests_failed;
   int     cycle_count;
   integer seed;

   opc_system UUT (
      .clk        (clk),
      .reset_b    (reset_b),
      .load       (load),
      .in_port    (in_port),
      .out_port   (out_port),
      .out_strobe (out_strobe)
   );

   always #clk_half clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles)
      begin
         $display("Run stopped after %0d cycles, test %s never finished.",
                  cycle_count, current_test);
         $display("Verification failed");
         $finish;
      end
   end

   // Capture each output write.
   always @(negedge clk)
   begin
      if (reset_b === 1'b1 && out_strobe === 1'b1)
         out_q.push_back(out_port);
   end

   ////////////////////////////////////////////////////////////
   // Program building
   ////////////////////////////////////////////////////////////

   function automatic word_t encode_instr(input logic [1:0] pred, input logic ind,
                                          input opcode_t op, input reg_idx_t dst,
                                          input reg_idx_t src);
      instr_t instr;
      instr          = '0;
      instr.pred_c   = pred[1];
      instr.pred_nz  = pred[0];
      instr.indirect = ind;
      instr.op       = op;
      instr.src      = src;
      instr.dst      = dst;
      return word_t'(instr);
   endfunction

   task automatic emit_instr(input logic [1:0] pred, input logic ind, input opcode_t op,
                             input reg_idx_t dst, input reg_idx_t src, input word_t operand);
      prog_q.push_back(encode_instr(pred, ind, op, dst, src));
      prog_q.push_back(operand);
   endtask

   // Jump to itself.
   task automatic emit_halt();
      word_t here;
      here = word_t'(prog_q.size());
      emit_instr(run_always, 1'b0, OP_LD, 4'd15, 4'd0, here);
   endtask

   task automatic preload_word(input mem_addr_t address, input word_t data);
      extra_addr_q.push_back(address);
      extra_data_q.push_back(data);
   endtask

   ////////////////////////////////////////////////////////////
   // Checking and reporting
   ////////////////////////////////////////////////////////////

   task automatic compare_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         $display("error %s: got 0x%h, expected 0x%h", name, actual, expected);
         error_count = error_count + 1;
         test_errors = test_errors + 1;
      end
   endtask

   task automatic begin_test(input string name);
      current_test = name;
      test_errors  = 0;
      prog_q.delete();
      extra_addr_q.delete();
      extra_data_q.delete();
      exp_q.delete();
   endtask

   task automatic end_test();
      tests_run = tests_run + 1;
      if (test_errors == 0)
         $display("Test %s: pass", current_test);
      else
      begin
         tests_failed = tests_failed + 1;
         $display("Test %s: %0d mismatches", current_test, test_errors);
      end
   endtask

   // Load in reset, release, wait for the outputs, then compare.
   task automatic run_program();
      int i;
      @(posedge clk);
      #drive_delay;
      reset_b = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      for (i = 0; i < prog_q.size(); i++)
      begin
         load.en      = 1'b1;
         load.address = mem_addr_t'(i);
         load.data    = prog_q[i];
         @(posedge clk);
         #drive_delay;
      end
      for (i = 0; i < extra_addr_q.size(); i++)
      begin
         load.en      = 1'b1;
         load.address = extra_addr_q[i];
         load.data    = extra_data_q[i];
         @(posedge clk);
         #drive_delay;
      end
      load    = '0;
      out_q.delete();
      compare_word("out_port", out_port, 16'h0000);   // Reset value.
      compare_word("out_strobe", word_t'(out_strobe), 16'h0000);
      reset_b = 1'b1;
      while (out_q.size() < exp_q.size())
         @(posedge clk);
      repeat (tail_cycles) @(posedge clk);
      @(negedge clk);
      compare_word("out_strobe count", word_t'(out_q.size()), word_t'(exp_q.size()));
      for (i = 0; i < exp_q.size() && i < out_q.size(); i++)
         compare_word($sformatf("out_port[%0d]", i), out_q[i], exp_q[i]);
      if (exp_q.size() > 0)
         compare_word("out_port", out_port, exp_q[exp_q.size()-1]);
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic load_and_output();
      begin_test("load_and_output");
      emit_instr(run_always, 1'b0, OP_LD, 4'd1, 4'd0, 16'h1234);
      emit_instr(run_always, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_halt();
      exp_q.push_back(16'h1234);
      run_program();
      end_test();
   endtask

   task automatic add_carry_predicates();
      begin_test("add_carry_predicates");
      emit_instr(run_always, 1'b0, OP_LD, 4'd1, 4'd0, 16'hffff);
      emit_instr(run_always, 1'b0, OP_ADD, 4'd1, 4'd0, 16'h0002);   // Carry out.
      emit_instr(run_always, 1'b0, OP_LD, 4'd2, 4'd0, 16'h0000);    // Zero set.
      emit_instr(run_if_carry, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_instr(run_if_nz, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_halt();
      exp_q.push_back(16'h0001);
      run_program();
      end_test();
   endtask

   task automatic nand_zero();
      begin_test("nand_zero");
      emit_instr(run_always, 1'b0, OP_LD, 4'd1, 4'd0, 16'hf0f0);
      emit_instr(run_always, 1'b0, OP_NAND, 4'd1, 4'd0, 16'hff00);
      emit_instr(run_always, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_instr(run_always, 1'b0, OP_LD, 4'd2, 4'd0, 16'hffff);
      emit_instr(run_always, 1'b0, OP_NAND, 4'd2, 4'd0, 16'hffff);
      emit_instr(run_if_nz, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_instr(run_always, 1'b0, OP_STO, 4'd2, 4'd0, `OPC_IO_OUT_ADDR);
      emit_halt();
      exp_q.push_back(16'h0fff);
      exp_q.push_back(16'h0000);
      run_program();
      end_test();
   endtask

   task automatic indirect_memory();
      begin_test("indirect_memory");
      emit_instr(run_always, 1'b0, OP_LD, 4'd1, 4'd0, 16'ha5c3);
      emit_instr(run_always, 1'b0, OP_LD, 4'd3, 4'd0, 16'h0700);    // Base.
      emit_instr(run_always, 1'b0, OP_STO, 4'd1, 4'd3, 16'h0100);
      emit_instr(run_always, 1'b1, OP_LD, 4'd2, 4'd3, 16'h0100);
      emit_instr(run_always, 1'b0, OP_STO, 4'd2, 4'd0, `OPC_IO_OUT_ADDR);
      emit_halt();
      preload_word(12'h800, 16'h0000);
      exp_q.push_back(16'ha5c3);
      run_program();
      end_test();
   endtask

   task automatic jump_loop();
      word_t loop_addr;
      int    n;
      begin_test("jump_loop");
      emit_instr(run_always, 1'b0, OP_LD, 4'd1, 4'd0, 16'h0005);
      loop_addr = word_t'(prog_q.size());
      emit_instr(run_always, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_instr(run_always, 1'b0, OP_ADD, 4'd1, 4'd0, 16'hffff);   // Count down.
      emit_instr(run_if_nz, 1'b0, OP_LD, 4'd15, 4'd0, loop_addr);
      emit_halt();
      for (n = 5; n >= 1; n--)
         exp_q.push_back(word_t'(n));
      run_program();
      end_test();
   endtask

   task automatic input_port_add();
      logic [31:0] rnd;
      word_t       in_val;
      word_t       sum;
      begin_test("input_port_add");
      rnd    = $random(seed);
      in_val = rnd[15:0];
      sum    = in_val + 16'd1;
      @(posedge clk);
      #drive_delay;
      in_port = in_val;
      emit_instr(run_always, 1'b1, OP_LD, 4'd1, 4'd0, `OPC_IO_IN_ADDR);
      emit_instr(run_always, 1'b0, OP_ADD, 4'd1, 4'd0, 16'h0001);
      emit_instr(run_always, 1'b0, OP_STO, 4'd1, 4'd0, `OPC_IO_OUT_ADDR);
      emit_halt();
      exp_q.push_back(sum);
      run_program();
      end_test();
   endtask

   initial
   begin
      clk          = 1'b0;
      reset_b      = 1'b0;
      load         = '0;
      in_port      = '0;
      seed         = 32'h0edd_4929;
      cycle_count  = 0;
      error_count  = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      current_test = "startup";

      load_and_output();
      add_carry_predicates();
      nand_zero();
      indirect_memory();
      jump_loop();
      input_port_add();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* opc_system.f */
+incdir+logic
logic/opc_pkg.sv
logic/opc_cpu.sv
logic/opc_memory.sv
logic/opc_io_port.sv
logic/opc_bus_return.sv
logic/opc_system.sv
verif/opc_system_tb.sv
